// File: source/ex_mem_slice_pkg.sv
package ex_mem_slice_pkg;

    localparam int REG_ADDR_W = 5;
    localparam int DATA_W     = 32;
    localparam int IMM_W      = 16;
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

    // NOP sits at zero so a cleared record decodes as a bubble
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_SLT  = 4'd6,
        OP_ADDI = 4'd7,
        OP_ORI  = 4'd8,
        OP_MULT = 4'd9,
        OP_MTHI = 4'd10,
        OP_MTLO = 4'd11,
        OP_MFHI = 4'd12,
        OP_MFLO = 4'd13,
        OP_LW   = 4'd14,
        OP_SW   = 4'd15
    } alu_op_e;

    // Decoded instruction as it leaves the decode stage
    typedef struct packed {
        alu_op_e                 aluop;
        logic [REG_ADDR_W-1:0]   wd;
        logic [DATA_W-1:0]       rs_val;
        logic [DATA_W-1:0]       rt_val;
        logic [IMM_W-1:0]        imm;
    } ex_req_t;

    // Execute result carried through the EX/MEM register
    typedef struct packed {
        logic [REG_ADDR_W-1:0]   wd;
        logic                    wreg;
        logic [2*DATA_W-1:0]     wdata;  // Full product for MULT, low half otherwise
        logic                    mt_hi;
        logic                    mt_lo;
        logic                    mf_hi;
        logic                    mf_lo;
        logic                    rmem;
        logic                    wmem;
        alu_op_e                 aluop;
        logic [DATA_W-1:0]       mem_addr;
    } ex_mem_t;

    // Write-back record for the register file
    typedef struct packed {
        logic [REG_ADDR_W-1:0]   wd;
        logic [DATA_W-1:0]       wdata;
    } wb_t;

endpackage

// File: source/exec_unit.sv
`timescale 1ns/1ns

module exec_unit (
    input  ex_mem_slice_pkg::ex_req_t req_i,
    input  logic                      req_valid_i,
    output logic                      req_ready_o,

    output ex_mem_slice_pkg::ex_mem_t ex_o,
    output logic                      ex_valid_o,
    input  logic                      ex_ready_i
);
    import ex_mem_slice_pkg::*;

    logic [DATA_W-1:0]          imm_sext;
    logic [DATA_W-1:0]          imm_zext;
    logic signed [2*DATA_W-1:0] product;

    // Purely combinational stage, so the handshake passes straight through
    assign ex_valid_o  = req_valid_i;
    assign req_ready_o = ex_ready_i;

    assign imm_sext = {{(DATA_W-IMM_W){req_i.imm[IMM_W-1]}}, req_i.imm};
    assign imm_zext = {{(DATA_W-IMM_W){1'b0}}, req_i.imm};
    assign product  = (2*DATA_W)'($signed(req_i.rs_val)) * (2*DATA_W)'($signed(req_i.rt_val));

    always_comb begin
        ex_o       = '0;
        ex_o.wd    = req_i.wd;
        ex_o.aluop = req_i.aluop;

        case (req_i.aluop)
            OP_ADD: begin
                ex_o.wreg              = 1'b1;
                ex_o.wdata[DATA_W-1:0] = req_i.rs_val + req_i.rt_val;
            end
            OP_SUB: begin
                ex_o.wreg              = 1'b1;
                ex_o.wdata[DATA_W-1:0] = req_i.rs_val - req_i.rt_val;
            end
            OP_AND: begin
                ex_o.wreg              = 1'b1;
                ex_o.wdata[DATA_W-1:0] = req_i.rs_val & req_i.rt_val;
            end
            OP_OR: begin
                ex_o.wreg              = 1'b1;
                ex_o.wdata[DATA_W-1:0] = req_i.rs_val | req_i.rt_val;
            end
            OP_XOR: begin
                ex_o.wreg              = 1'b1;
                ex_o.wdata[DATA_W-1:0] = req_i.rs_val ^ req_i.rt_val;
            end
            OP_SLT: begin
                ex_o.wreg     = 1'b1;
                ex_o.wdata[0] = $signed(req_i.rs_val) < $signed(req_i.rt_val);
            end
            OP_ADDI: begin
                ex_o.wreg              = 1'b1;
                ex_o.wdata[DATA_W-1:0] = req_i.rs_val + imm_sext;
            end
            OP_ORI: begin
                ex_o.wreg              = 1'b1;
                ex_o.wdata[DATA_W-1:0] = req_i.rs_val | imm_zext;
            end
            OP_MULT: begin
                // Both halves go to HI/LO and the memory stage splits them
                ex_o.mt_hi = 1'b1;
                ex_o.mt_lo = 1'b1;
                ex_o.wdata = product;
            end
            OP_MTHI: begin
                ex_o.mt_hi             = 1'b1;
                ex_o.wdata[DATA_W-1:0] = req_i.rs_val;
            end
            OP_MTLO: begin
                ex_o.mt_lo             = 1'b1;
                ex_o.wdata[DATA_W-1:0] = req_i.rs_val;
            end
            OP_MFHI: begin
                ex_o.wreg  = 1'b1;
                ex_o.mf_hi = 1'b1;
            end
            OP_MFLO: begin
                ex_o.wreg  = 1'b1;
                ex_o.mf_lo = 1'b1;
            end
            OP_LW: begin
                ex_o.wreg     = 1'b1;
                ex_o.rmem     = 1'b1;
                ex_o.mem_addr = req_i.rs_val + imm_sext;
            end
            OP_SW: begin
                ex_o.wmem              = 1'b1;
                ex_o.mem_addr          = req_i.rs_val + imm_sext;
                ex_o.wdata[DATA_W-1:0] = req_i.rt_val;  // Store data
            end
            default: begin
                ex_o.wreg = 1'b0;  // NOP leaves every flag clear
            end
        endcase
    end

endmodule

// File: source/ex_mem_reg.sv
`timescale 1ns/1ns

module ex_mem_reg (
    input  logic                      clk_i,
    input  logic                      rst_i,

    input  ex_mem_slice_pkg::ex_mem_t ex_i,
    input  logic                      ex_valid_i,
    output logic                      ex_ready_o,

    output ex_mem_slice_pkg::ex_mem_t mem_o,
    output logic                      mem_valid_o,
    input  logic                      mem_ready_i
);
    import ex_mem_slice_pkg::*;

    ex_mem_t mem_q;
    logic    valid_q;

    // Room for a new record when empty or when the current one leaves this cycle
    assign ex_ready_o = ~valid_q | mem_ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mem_q   <= '0;
            valid_q <= 1'b0;
        end else if (ex_ready_o) begin
            mem_q   <= ex_i;
            valid_q <= ex_valid_i;
        end
    end

    // Outside the load branch both hold their contents
    assign mem_o       = mem_q;
    assign mem_valid_o = valid_q;

endmodule

// File: source/mem_stage.sv
`timescale 1ns/1ns

module mem_stage (
    input  logic                      clk_i,
    input  logic                      rst_i,

    input  ex_mem_slice_pkg::ex_mem_t mem_i,
    input  logic                      mem_valid_i,
    output logic                      mem_ready_o,

    output ex_mem_slice_pkg::wb_t     wb_o,
    output logic                      wb_valid_o,
    input  logic                      wb_ready_i
);
    import ex_mem_slice_pkg::*;

    logic [DATA_W-1:0]     dmem [DMEM_WORDS];
    logic [DATA_W-1:0]     hi_q;
    logic [DATA_W-1:0]     lo_q;
    logic [DMEM_IDX_W-1:0] word_idx;
    logic                  consume;
    logic [DATA_W-1:0]     wb_data;

    assign mem_ready_o = ~wb_valid_o | wb_ready_i;
    assign consume     = mem_valid_i & mem_ready_o;

    // Word index drops the byte offset and wraps at the memory size
    assign word_idx = mem_i.mem_addr[DMEM_IDX_W+1:2];

    always_comb begin
        if (mem_i.rmem) begin
            wb_data = dmem[word_idx];
        end else if (mem_i.mf_hi) begin
            wb_data = hi_q;
        end else if (mem_i.mf_lo) begin
            wb_data = lo_q;
        end else begin
            wb_data = mem_i.wdata[DATA_W-1:0];  // ALU result
        end
    end

    always_ff @(posedge clk_i) begin
        if (consume && mem_i.wmem) begin
            dmem[word_idx] <= mem_i.wdata[DATA_W-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (consume) begin
            if (mem_i.mt_hi) begin
                // MULT takes the upper product half, MTHI the moved value
                hi_q <= (mem_i.aluop == OP_MULT) ? mem_i.wdata[2*DATA_W-1:DATA_W]
                                                 : mem_i.wdata[DATA_W-1:0];
            end
            if (mem_i.mt_lo) begin
                lo_q <= mem_i.wdata[DATA_W-1:0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
        end else if (consume && mem_i.wreg) begin
            wb_valid_o <= 1'b1;
        end else if (wb_ready_i) begin
            wb_valid_o <= 1'b0;  // Drained with nothing behind it
        end
    end

    always_ff @(posedge clk_i) begin
        if (consume && mem_i.wreg) begin
            wb_o.wd    <= mem_i.wd;
            wb_o.wdata <= wb_data;
        end
    end

endmodule

// File: source/ex_mem_slice_top.sv
`timescale 1ns/1ns

module ex_mem_slice_top (
    input  logic                      clk_i,
    input  logic                      rst_i,

    input  ex_mem_slice_pkg::ex_req_t req_i,
    input  logic                      req_valid_i,
    output logic                      req_ready_o,

    output ex_mem_slice_pkg::wb_t     wb_o,
    output logic                      wb_valid_o,
    input  logic                      wb_ready_i
);
    import ex_mem_slice_pkg::*;

    ex_mem_t ex_rec;
    logic    ex_valid;
    logic    ex_ready;
    ex_mem_t mem_rec;
    logic    mem_valid;
    logic    mem_ready;

    exec_unit exec_unit_i (
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .ex_o        (ex_rec),
        .ex_valid_o  (ex_valid),
        .ex_ready_i  (ex_ready)
    );

    ex_mem_reg ex_mem_reg_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .ex_i        (ex_rec),
        .ex_valid_i  (ex_valid),
        .ex_ready_o  (ex_ready),
        .mem_o       (mem_rec),
        .mem_valid_o (mem_valid),
        .mem_ready_i (mem_ready)
    );

    mem_stage mem_stage_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .mem_i       (mem_rec),
        .mem_valid_i (mem_valid),
        .mem_ready_o (mem_ready),
        .wb_o        (wb_o),
        .wb_valid_o  (wb_valid_o),
        .wb_ready_i  (wb_ready_i)
    );

endmodule

// File: testbench/ex_mem_slice_checker.sv
`timescale 1ns/1ns

module ex_mem_slice_checker (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  req_valid_i,
    input  logic                  req_ready_i,
    input  logic                  exp_wr_i,
    input  ex_mem_slice_pkg::wb_t exp_i,
    input  ex_mem_slice_pkg::wb_t wb_i,
    input  logic                  wb_valid_i,
    input  logic                  wb_ready_i,
    input  logic                  done_i,
    output int                    err_count_o,
    output int                    checked_o,
    output int                    pending_o
);
    import ex_mem_slice_pkg::*;

    wb_t  expected [$];
    wb_t  next_exp;
    int   errors  = 0;
    int   checked = 0;
    int   pending = 0;
    logic done_seen = 1'b0;

    assign err_count_o = errors;
    assign checked_o   = checked;
    assign pending_o   = pending;

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected_val);
        if (actual !== expected_val) begin
            $display("FAIL %0t %s actual %h expected %h", $time, name, actual, expected_val);
            errors++;
        end
    endtask

    always @(posedge clk_i) begin
        if (rst_i && wb_valid_i) begin
            $display("Write-back valid raised during reset at %0t", $time);
            errors++;
        end
        if (!rst_i && wb_valid_i && wb_ready_i) begin
            if (expected.size() == 0) begin
                $display("Write-back to r%0d at %0t arrived with nothing left to expect",
                         wb_i.wd, $time);
                errors++;
            end else begin
                next_exp = expected.pop_front();
                compare_value("wb_o.wd", 32'(wb_i.wd), 32'(next_exp.wd));
                compare_value("wb_o.wdata", wb_i.wdata, next_exp.wdata);
                checked++;
            end
        end
        // A writing instruction is expected from the edge it enters the pipeline
        if (!rst_i && req_valid_i && req_ready_i && exp_wr_i) begin
            expected.push_back(exp_i);
        end
        if (done_i && !done_seen) begin
            done_seen = 1'b1;
            if (expected.size() != 0) begin
                $display("%0d expected write-backs never arrived", expected.size());
                errors++;
            end
        end
        pending = expected.size();
    end

endmodule

// File: testbench/ex_mem_slice_tb.sv
`timescale 1ns/1ns

module ex_mem_slice_tb;
    import ex_mem_slice_pkg::*;

    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 10;
    localparam int NUM_ROWS       = 25;
    localparam int CYCLES_PER_ROW = 20;
    localparam int DRAIN_LIMIT    = 50;

    typedef struct packed {
        ex_req_t           req;
        logic              wr;       // Row produces a write-back
        logic [DATA_W-1:0] wb_data;
    } row_t;

    logic    clk_i      = 1'b0;
    logic    rst_i;
    ex_req_t req_i;
    logic    req_valid_i;
    logic    req_ready_o;
    wb_t     wb_o;
    logic    wb_valid_o;
    logic    wb_ready_i = 1'b0;
    logic    exp_wr;
    wb_t     exp_rec;
    logic    done;
    int      errors;
    int      checked;
    int      pending;
    integer  seed       = 32'h232cb1bc;
    row_t    rows [NUM_ROWS];
    int      n_rows     = 0;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    always @(posedge clk_i) wb_ready_i <= ($random(seed) & 3) != 0;  // Low one cycle in four

    ex_mem_slice_top ex_mem_slice_top_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .wb_o        (wb_o),
        .wb_valid_o  (wb_valid_o),
        .wb_ready_i  (wb_ready_i)
    );

    ex_mem_slice_checker ex_mem_slice_checker_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_ready_i (req_ready_o),
        .exp_wr_i    (exp_wr),
        .exp_i       (exp_rec),
        .wb_i        (wb_o),
        .wb_valid_i  (wb_valid_o),
        .wb_ready_i  (wb_ready_i),
        .done_i      (done),
        .err_count_o (errors),
        .checked_o   (checked),
        .pending_o   (pending)
    );

    task automatic add_row(input alu_op_e op, input logic [4:0] wd, input logic [31:0] rs,
                           input logic [31:0] rt, input logic [15:0] imm,
                           input logic wr, input logic [31:0] wb_data);
        rows[n_rows].req     = '{aluop: op, wd: wd, rs_val: rs, rt_val: rt, imm: imm};
        rows[n_rows].wr      = wr;
        rows[n_rows].wb_data = wb_data;
        n_rows++;
    endtask

    task automatic load_rows();
        add_row(OP_MFHI,  5'd1,  32'h0,         32'h0,         16'h0,    1'b1, 32'h0);
        add_row(OP_ADD,   5'd2,  32'h5,         32'h7,         16'h0,    1'b1, 32'h0000_000c);
        add_row(OP_SUB,   5'd3,  32'h5,         32'h7,         16'h0,    1'b1, 32'hffff_fffe);
        add_row(OP_AND,   5'd4,  32'hf0f0_1234, 32'h0ff0_ff00, 16'h0,    1'b1, 32'h00f0_1200);
        add_row(OP_OR,    5'd5,  32'hf0f0_1234, 32'h0ff0_ff00, 16'h0,    1'b1, 32'hfff0_ff34);
        add_row(OP_XOR,   5'd6,  32'hf0f0_1234, 32'h0ff0_ff00, 16'h0,    1'b1, 32'hff00_ed34);
        add_row(OP_SLT,   5'd7,  32'hffff_ffff, 32'h1,         16'h0,    1'b1, 32'h1);
        add_row(OP_SLT,   5'd8,  32'h1,         32'hffff_ffff, 16'h0,    1'b1, 32'h0);
        add_row(OP_ADDI,  5'd9,  32'h100,       32'h0,         16'hfff0, 1'b1, 32'h0000_00f0);
        add_row(OP_ORI,   5'd10, 32'h0001_0000, 32'h0,         16'h8001, 1'b1, 32'h0001_8001);
        add_row(OP_MTHI,  5'd0,  32'h1234_5678, 32'h0,         16'h0,    1'b0, 32'h0);
        add_row(OP_MTLO,  5'd0,  32'h9abc_def0, 32'h0,         16'h0,    1'b0, 32'h0);
        add_row(OP_MFHI,  5'd11, 32'h0,         32'h0,         16'h0,    1'b1, 32'h1234_5678);
        add_row(OP_MFLO,  5'd12, 32'h0,         32'h0,         16'h0,    1'b1, 32'h9abc_def0);
        // -0x12345 times -0x10001 gives 0x1_2346_2345
        add_row(OP_MULT,  5'd0,  32'hfffe_dcbb, 32'hfffe_ffff, 16'h0,    1'b0, 32'h0);
        add_row(OP_MFHI,  5'd13, 32'h0,         32'h0,         16'h0,    1'b1, 32'h0000_0001);
        add_row(OP_MFLO,  5'd14, 32'h0,         32'h0,         16'h0,    1'b1, 32'h2346_2345);
        add_row(OP_SW,    5'd0,  32'h48,        32'hcafe_f00d, 16'hfff8, 1'b0, 32'h0);
        add_row(OP_SW,    5'd0,  32'h48,        32'h0bad_beef, 16'hfffc, 1'b0, 32'h0);
        add_row(OP_LW,    5'd15, 32'h48,        32'h0,         16'hfff8, 1'b1, 32'hcafe_f00d);
        add_row(OP_LW,    5'd16, 32'h50,        32'h0,         16'hfff4, 1'b1, 32'h0bad_beef);
        add_row(OP_NOP,   5'd0,  32'h0,         32'h0,         16'h0,    1'b0, 32'h0);
        add_row(OP_MTHI,  5'd0,  32'h5555_aaaa, 32'h0,         16'h0,    1'b0, 32'h0);
        add_row(OP_MFHI,  5'd17, 32'h0,         32'h0,         16'h0,    1'b1, 32'h5555_aaaa);
        add_row(OP_ADD,   5'd31, 32'h7fff_ffff, 32'h1,         16'h0,    1'b1, 32'h8000_0000);
    endtask

    initial begin
        #((NUM_ROWS * CYCLES_PER_ROW + RESET_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired at %0t with the pipeline still busy", $time);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        logic ready_seen;
        int   wait_cycles;
        rst_i       = 1'b1;
        req_i       = '0;
        req_valid_i = 1'b0;
        exp_wr      = 1'b0;
        exp_rec     = '0;
        done        = 1'b0;
        load_rows();
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            req_i       <= rows[i].req;
            req_valid_i <= 1'b1;
            exp_wr      <= rows[i].wr;
            exp_rec     <= '{wd: rows[i].req.wd, wdata: rows[i].wb_data};
            do begin
                @(negedge clk_i);
                ready_seen = req_ready_o;  // Inputs only move on the rising edge
                @(posedge clk_i);
            end while (!ready_seen);
        end
        req_valid_i <= 1'b0;
        exp_wr      <= 1'b0;
        wait_cycles = 0;
        do begin
            @(negedge clk_i);
            wait_cycles++;
        end while (pending != 0 && wait_cycles < DRAIN_LIMIT);
        repeat (4) @(posedge clk_i);  // Room for a stray extra write-back to show up
        done <= 1'b1;
        @(posedge clk_i);
        @(negedge clk_i);
        $display("Write-backs checked: %0d, errors: %0d", checked, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: ex_mem_slice.f
source/ex_mem_slice_pkg.sv
source/exec_unit.sv
source/ex_mem_reg.sv
source/mem_stage.sv
source/ex_mem_slice_top.sv
testbench/ex_mem_slice_checker.sv
testbench/ex_mem_slice_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module ex_mem_slice_tb \
    -f ex_mem_slice.f --Mdir obj_dir -o ex_mem_slice_sim

./obj_dir/ex_mem_slice_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log || ! grep -q "Test OK" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
